// ==== testbench/decodeStim.mem ====
// grp wen waddr wdata pc instr exMemRead exRt | pcWrite ctrl regA regB imm rs rt rd
// ctrl bits: regWrite memToReg branch memRead memWrite regDst aluOp[1:0] aluSrc
// Register write, then read in the next vector, r0 write ignored
1 1 5 12345678 00400000 00221820 0 0 1 10c 0 0 1820 1 2 3
1 1 9 cafef00d 00400004 00a63820 0 0 1 10c 12345678 0 3820 5 6 7
1 1 0 deadbeef 00400008 ad250010 0 0 1 11 cafef00d 12345678 10 9 5 0
1 0 0 0 0040000c 00052020 0 0 1 10c 0 12345678 2020 0 5 4
// Write and read of the same register in one cycle
2 1 7 0badc0de 00400010 00e9402a 0 0 1 10c 0badc0de cafef00d 402a 7 9 8
2 1 9 55aa55aa 00400014 10e9fffc 0 0 1 42 0badc0de 55aa55aa fffffffc 7 9 1f
// Decode table, each opcode with a positive and a negative immediate
3 0 0 0 00400018 00a72820 0 0 1 10c 12345678 0badc0de 2820 5 7 5
3 0 0 0 0040001c 00a7f822 0 0 1 10c 12345678 0badc0de fffff822 5 7 1f
3 0 0 0 00400020 8ca70004 0 0 1 1a1 12345678 0badc0de 4 5 7 0
3 0 0 0 00400024 8ca7fff0 0 0 1 1a1 12345678 0badc0de fffffff0 5 7 1f
3 0 0 0 00400028 aca70008 0 0 1 11 12345678 0badc0de 8 5 7 0
3 0 0 0 0040002c aca78000 0 0 1 11 12345678 0badc0de ffff8000 5 7 10
3 0 0 0 00400030 10a70003 0 0 1 42 12345678 0badc0de 3 5 7 0
3 0 0 0 00400034 10a7ffff 0 0 1 42 12345678 0badc0de ffffffff 5 7 1f
3 0 0 0 00400038 20a77fff 0 0 1 101 12345678 0badc0de 7fff 5 7 f
3 0 0 0 0040003c 20a78001 0 0 1 101 12345678 0badc0de ffff8001 5 7 10
3 0 0 0 00400040 28a70064 0 0 1 107 12345678 0badc0de 64 5 7 0
3 0 0 0 00400044 28a7ff9c 0 0 1 107 12345678 0badc0de ffffff9c 5 7 1f
// Unknown opcodes decode as a bubble
3 0 0 0 00400048 fca71234 0 0 1 0 12345678 0badc0de 1234 5 7 2
3 0 0 0 0040004c 08a7c000 0 0 1 0 12345678 0badc0de ffffc000 5 7 18
// Load-use stall on rs, on rt, then the no-stall cases
4 0 0 0 00400050 00a74020 1 5 0 0 12345678 0badc0de 4020 5 7 8
4 0 0 0 00400054 00a74020 1 7 0 0 12345678 0badc0de 4020 5 7 8
4 0 0 0 00400058 8c070100 1 0 1 1a1 0 0badc0de 100 0 7 0
4 0 0 0 0040005c 00a74020 1 9 1 10c 12345678 0badc0de 4020 5 7 8
4 0 0 0 00400060 00a74020 0 5 1 10c 12345678 0badc0de 4020 5 7 8

// ==== project.f ====
verilog/mipsDecodePkg.sv
verilog/regReadIf.sv
verilog/registerFile.sv
verilog/controlDecoder.sv
verilog/hazardDetector.sv
verilog/instructionDecode.sv
testbench/instructionDecodeTb.sv

// ==== Makefile ====
TOP := instructionDecodeTb

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run into sim.log, check the result"
	@echo "  clean  remove the build directory and the log"

test:
	verilator --binary --timescale 1ns/1ps --top-module $(TOP) -f project.f -Mdir obj_dir -o sim
	./obj_dir/sim | tee sim.log
	@if grep -q "Simulation PASSED" sim.log; then \
		echo "test: pass"; \
	else \
		echo "test: fail"; \
		exit 1; \
	fi

clean:
	rm -rf obj_dir sim.log

// ==== testbench/instructionDecodeTb.sv ====
`timescale 1ns/1ps

module instructionDecodeTb;
	import mipsDecodePkg::*;

	//////////////////////////////
	// Vector layout
	//////////////////////////////

	localparam int PERIOD = 8;
	localparam int FIELDS = 16;
	localparam int MAX_VECS = 64;
	// Group column of an unused slot
	localparam logic [31:0] EMPTY = 32'hFFFF_FFFF;

	// Column index inside one vector
	localparam int COL_GROUP = 0;
	localparam int COL_WEN = 1;
	localparam int COL_WADDR = 2;
	localparam int COL_WDATA = 3;
	localparam int COL_PC = 4;
	localparam int COL_INSTR = 5;
	localparam int COL_EXMEMREAD = 6;
	localparam int COL_EXRT = 7;
	// Expected values
	localparam int COL_PCWRITE = 8;
	localparam int COL_CTRL = 9;
	localparam int COL_REGA = 10;
	localparam int COL_REGB = 11;
	localparam int COL_IMM = 12;
	localparam int COL_RS = 13;
	localparam int COL_RT = 14;
	localparam int COL_RD = 15;

	logic clk;
	logic rst;
	logic regWrite;
	logic [REG_ADDR_W-1:0] regWriteAddr;
	logic [DATA_W-1:0] regWriteData;
	logic [DATA_W-1:0] instructionAddress;
	logic [DATA_W-1:0] instruction;
	logic exMemRead;
	logic [REG_ADDR_W-1:0] exRt;

	logic pcWrite;
	logic ifIdWrite;
	logic idRegWrite;
	logic idMemToReg;
	logic idBranch;
	logic idMemRead;
	logic idMemWrite;
	logic idRegDst;
	logic idAluSrc;
	aluOpT idAluOp;
	logic [DATA_W-1:0] idInstructionAddress;
	logic [DATA_W-1:0] idRegA;
	logic [DATA_W-1:0] idRegB;
	logic [DATA_W-1:0] idImm;
	logic [REG_ADDR_W-1:0] idRs;
	logic [REG_ADDR_W-1:0] idRt;
	logic [REG_ADDR_W-1:0] idRd;

	// Flat vector memory with FIELDS words per vector
	logic [31:0] stim [MAX_VECS*FIELDS];
	int vecCount;
	int checkCount;
	int errorCount;
	// Counters at the start of the running group
	int groupChecks;
	int groupErrors;
	bit loaded = 1'b0;

	instructionDecode dut0
	(
		.clk(clk),
		.rst(rst),
		.regWrite(regWrite),
		.regWriteAddr(regWriteAddr),
		.regWriteData(regWriteData),
		.instructionAddress(instructionAddress),
		.instruction(instruction),
		.exMemRead(exMemRead),
		.exRt(exRt),
		.pcWrite(pcWrite),
		.ifIdWrite(ifIdWrite),
		.idRegWrite(idRegWrite),
		.idMemToReg(idMemToReg),
		.idBranch(idBranch),
		.idMemRead(idMemRead),
		.idMemWrite(idMemWrite),
		.idRegDst(idRegDst),
		.idAluSrc(idAluSrc),
		.idAluOp(idAluOp),
		.idInstructionAddress(idInstructionAddress),
		.idRegA(idRegA),
		.idRegB(idRegB),
		.idImm(idImm),
		.idRs(idRs),
		.idRt(idRt),
		.idRd(idRd)
	);

	initial
	begin
		clk = 1'b0;
		forever #(PERIOD/2) clk = ~clk;
	end

	//////////////////////////////
	// Compare tasks
	//////////////////////////////

	task automatic checkBit(input string name, input logic exp, input logic act);
		checkCount++;
		if (act !== exp)
		begin
			errorCount++;
			$display("ERROR t=%0t %s expected %b actual %b", $time, name, exp, act);
		end
	endtask

	task automatic checkCtrl(input string name, input ctrlT exp, input ctrlT act);
		checkCount++;
		if (act !== exp)
		begin
			errorCount++;
			$display("ERROR t=%0t %s expected %h actual %h", $time, name, exp, act);
		end
	endtask

	task automatic checkWord(input string name, input logic [DATA_W-1:0] exp,
		input logic [DATA_W-1:0] act);
		checkCount++;
		if (act !== exp)
		begin
			errorCount++;
			$display("ERROR t=%0t %s expected %h actual %h", $time, name, exp, act);
		end
	endtask

	task automatic checkAddr(input string name, input logic [REG_ADDR_W-1:0] exp,
		input logic [REG_ADDR_W-1:0] act);
		checkCount++;
		if (act !== exp)
		begin
			errorCount++;
			$display("ERROR t=%0t %s expected %h actual %h", $time, name, exp, act);
		end
	endtask

	//////////////////////////////
	// Helpers
	//////////////////////////////

	// Control groups as seen on the ID/EX ports
	function automatic ctrlT latchedCtrl();
		return ctrlT'({idRegWrite, idMemToReg, idBranch, idMemRead, idMemWrite,
			idRegDst, idAluOp, idAluSrc});
	endfunction

	function automatic string groupName(input int g);
		case (g)
			0: return "reset";
			1: return "register write and read";
			2: return "write-through";
			3: return "decode table";
			4: return "load-use stall";
			default: return "unnamed";
		endcase
	endfunction

	task automatic startGroup();
		groupChecks = checkCount;
		groupErrors = errorCount;
	endtask

	task automatic reportGroup(input int g);
		$display("Test %0d %s: %0d checks, %0d errors", g, groupName(g),
			checkCount - groupChecks, errorCount - groupErrors);
	endtask

	task automatic driveVector(input int v);
		int b;
		b = v * FIELDS;
		regWrite = stim[b + COL_WEN][0];
		regWriteAddr = stim[b + COL_WADDR][REG_ADDR_W-1:0];
		regWriteData = stim[b + COL_WDATA];
		instructionAddress = stim[b + COL_PC];
		instruction = stim[b + COL_INSTR];
		exMemRead = stim[b + COL_EXMEMREAD][0];
		exRt = stim[b + COL_EXRT][REG_ADDR_W-1:0];
	endtask

	// Stall outputs within the same cycle
	task automatic checkHold(input int v);
		int b;
		b = v * FIELDS;
		checkBit("pcWrite", stim[b + COL_PCWRITE][0], pcWrite);
		checkBit("ifIdWrite", stim[b + COL_PCWRITE][0], ifIdWrite);
	endtask

	// ID/EX contents one edge later
	task automatic checkLatch(input int v);
		int b;
		b = v * FIELDS;
		checkCtrl("ctrl", ctrlT'(stim[b + COL_CTRL][8:0]), latchedCtrl());
		checkWord("idInstructionAddress", stim[b + COL_PC], idInstructionAddress);
		checkWord("idRegA", stim[b + COL_REGA], idRegA);
		checkWord("idRegB", stim[b + COL_REGB], idRegB);
		checkWord("idImm", stim[b + COL_IMM], idImm);
		checkAddr("idRs", stim[b + COL_RS][REG_ADDR_W-1:0], idRs);
		checkAddr("idRt", stim[b + COL_RT][REG_ADDR_W-1:0], idRt);
		checkAddr("idRd", stim[b + COL_RD][REG_ADDR_W-1:0], idRd);
	endtask

	task automatic checkReset();
		checkCtrl("ctrl", ctrlT'('0), latchedCtrl());
		checkWord("idInstructionAddress", '0, idInstructionAddress);
		checkWord("idRegA", '0, idRegA);
		checkWord("idRegB", '0, idRegB);
		checkWord("idImm", '0, idImm);
		checkAddr("idRs", '0, idRs);
		checkAddr("idRt", '0, idRt);
		checkAddr("idRd", '0, idRd);
	endtask

	//////////////////////////////
	// Main sequence
	//////////////////////////////

	initial
	begin
		int curGroup;
		int g;
		// Nonzero inputs on every field under reset
		// lw with rs, rt and rd all r5, write to r5 bypasses onto both reads
		rst = 1'b1;
		regWrite = 1'b1;
		regWriteAddr = 5'd5;
		regWriteData = 32'h1111_2222;
		instructionAddress = 32'h0040_0000;
		instruction = 32'h8CA5_2804;
		exMemRead = 1'b0;
		exRt = '0;
		checkCount = 0;
		errorCount = 0;

		for (int i = 0; i < MAX_VECS*FIELDS; i++)
			stim[i] = EMPTY;
		$readmemh("testbench/decodeStim.mem", stim);
		vecCount = 0;
		while (vecCount < MAX_VECS && stim[vecCount*FIELDS + COL_GROUP] != EMPTY)
			vecCount++;
		loaded = 1'b1;
		if (vecCount == 0)
		begin
			$display("No stimulus vectors were found in testbench/decodeStim.mem");
			errorCount++;
		end

		repeat (2) @(posedge clk);
		#1;
		startGroup();
		checkReset();
		reportGroup(0);
		rst = 1'b0;

		curGroup = -1;
		for (int v = 0; v < vecCount; v++)
		begin
			g = stim[v*FIELDS + COL_GROUP];
			if (g != curGroup)
			begin
				if (curGroup >= 0)
					reportGroup(curGroup);
				curGroup = g;
				startGroup();
			end
			driveVector(v);
			// Just before the edge
			#(PERIOD - 2);
			checkHold(v);
			@(posedge clk);
			#1;
			checkLatch(v);
		end
		if (curGroup >= 0)
			reportGroup(curGroup);

		$display("Done: %0d vectors, %0d checks, %0d errors", vecCount, checkCount, errorCount);
		if (errorCount == 0)
			$display("Simulation PASSED");
		else
			$display("Simulation FAILED");
		$finish;
	end

	// Watchdog sized from the vector count
	initial
	begin
		wait (loaded);
		#((vecCount + 10) * PERIOD);
		$display("Timeout: the run did not finish within %0d clock cycles", vecCount + 10);
		$display("Simulation FAILED");
		$finish;
	end

endmodule

// ==== verilog/instructionDecode.sv ====
`timescale 1ns/1ps

// ID stage: register read, main control, load-use check, ID/EX latch
module instructionDecode
(
	input logic clk,
	input logic rst,

	// Write-back port from the last stage
	input logic regWrite,
	input logic [mipsDecodePkg::REG_ADDR_W-1:0] regWriteAddr,
	input logic [mipsDecodePkg::DATA_W-1:0] regWriteData,

	// From IF/ID
	input logic [mipsDecodePkg::DATA_W-1:0] instructionAddress,
	input logic [mipsDecodePkg::DATA_W-1:0] instruction,

	// From ID/EX, the instruction now in execute
	input logic exMemRead,
	input logic [mipsDecodePkg::REG_ADDR_W-1:0] exRt,

	// Hold controls back to fetch
	output logic pcWrite,
	output logic ifIdWrite,

	// ID/EX control groups
	output logic idRegWrite,
	output logic idMemToReg,
	output logic idBranch,
	output logic idMemRead,
	output logic idMemWrite,
	output logic idRegDst,
	output logic idAluSrc,
	output mipsDecodePkg::aluOpT idAluOp,

	// ID/EX data fields
	output logic [mipsDecodePkg::DATA_W-1:0] idInstructionAddress,
	output logic [mipsDecodePkg::DATA_W-1:0] idRegA,
	output logic [mipsDecodePkg::DATA_W-1:0] idRegB,
	output logic [mipsDecodePkg::DATA_W-1:0] idImm,
	output logic [mipsDecodePkg::REG_ADDR_W-1:0] idRs,
	output logic [mipsDecodePkg::REG_ADDR_W-1:0] idRt,
	output logic [mipsDecodePkg::REG_ADDR_W-1:0] idRd
);
	import mipsDecodePkg::*;

	//////////////////////////////
	// Instruction fields
	//////////////////////////////

	opcodeT opcodeField;
	logic [REG_ADDR_W-1:0] rsField;
	logic [REG_ADDR_W-1:0] rtField;
	logic [REG_ADDR_W-1:0] rdField;
	logic [IMM_W-1:0] immField;
	logic [DATA_W-1:0] immExt;

	assign opcodeField = opcodeT'(instruction[31:26]);
	assign rsField = instruction[25:21];
	assign rtField = instruction[20:16];
	assign rdField = instruction[15:11];
	assign immField = instruction[IMM_W-1:0];

	// Sign-extend, logical ops included
	assign immExt = {{(DATA_W - IMM_W){immField[IMM_W-1]}}, immField};

	//////////////////////////////
	// Sub-blocks
	//////////////////////////////

	regReadIf rdBus ();

	// Source indices go straight to the read ports
	assign rdBus.rs = rsField;
	assign rdBus.rt = rtField;

	registerFile regFile0
	(
		.clk(clk),
		.rst(rst),
		.regWrite(regWrite),
		.regWriteAddr(regWriteAddr),
		.regWriteData(regWriteData),
		.rd(rdBus.file)
	);

	ctrlT ctrlDecoded;
	ctrlT ctrlIssued;
	logic stall;

	controlDecoder ctrl0
	(
		.opcode(opcodeField),
		.ctrl(ctrlDecoded)
	);

	hazardDetector hdu0
	(
		.rs(rsField),
		.rt(rtField),
		.exMemRead(exMemRead),
		.exRt(exRt),
		.stall(stall)
	);

	// Freeze PC and IF/ID while the load finishes
	assign pcWrite = ~stall;
	assign ifIdWrite = ~stall;

	// Bubble: zero controls, data fields still pass
	assign ctrlIssued = stall ? ctrlT'('0) : ctrlDecoded;

	//////////////////////////////
	// ID/EX register
	//////////////////////////////

	ctrlT idCtrl;

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			idCtrl <= '0;
			idInstructionAddress <= '0;
			idRegA <= '0;
			idRegB <= '0;
			idImm <= '0;
			idRs <= '0;
			idRt <= '0;
			idRd <= '0;
		end
		else
		begin
			idCtrl <= ctrlIssued;
			idInstructionAddress <= instructionAddress;
			idRegA <= rdBus.dataA;
			idRegB <= rdBus.dataB;
			idImm <= immExt;
			// rs/rt/rd kept for forwarding and regDst in later stages
			idRs <= rsField;
			idRt <= rtField;
			idRd <= rdField;
		end
	end

	// Unpack latched control word onto the flat ports
	assign idRegWrite = idCtrl.regWrite;
	assign idMemToReg = idCtrl.memToReg;
	assign idBranch = idCtrl.branch;
	assign idMemRead = idCtrl.memRead;
	assign idMemWrite = idCtrl.memWrite;
	assign idRegDst = idCtrl.regDst;
	assign idAluSrc = idCtrl.aluSrc;
	assign idAluOp = idCtrl.aluOp;

endmodule

// ==== verilog/hazardDetector.sv ====
`timescale 1ns/1ps

// Load-use hazard check against the instruction in EX
module hazardDetector
(
	input logic [mipsDecodePkg::REG_ADDR_W-1:0] rs,
	input logic [mipsDecodePkg::REG_ADDR_W-1:0] rt,
	input logic exMemRead,
	input logic [mipsDecodePkg::REG_ADDR_W-1:0] exRt,
	output logic stall
);

	// EX holds a load with a real destination
	logic loadInEx;

	// Destination hits a source of the decoding instruction
	logic hitRs;
	logic hitRt;

	//////////////////////////////
	// Compare
	//////////////////////////////

	// r0 is never a true dependency
	assign loadInEx = exMemRead && (exRt != '0);

	assign hitRs = (exRt == rs);
	assign hitRt = (exRt == rt);

	// One bubble needed, loaded data is not ready before MEM
	// rt is checked even for I-type, costs an extra stall at worst
	assign stall = loadInEx && (hitRs || hitRt);

endmodule

// ==== verilog/controlDecoder.sv ====
`timescale 1ns/1ps

// Main control, opcode to WB / MEM / EX groups
// Purely combinational
module controlDecoder
(
	input mipsDecodePkg::opcodeT opcode,
	output mipsDecodePkg::ctrlT ctrl
);
	import mipsDecodePkg::*;

	always_comb
	begin
		// Start from a no-op, each opcode sets only its own bits
		ctrl = '0;

		case (opcode)
			// ALU register ops, result to rd
			opRType:
			begin
				ctrl.regWrite = 1'b1;
				ctrl.regDst = 1'b1;
				ctrl.aluOp = aluFunct;
			end

			// Load word, base + offset, data from memory to rt
			opLw:
			begin
				ctrl.regWrite = 1'b1;
				ctrl.memToReg = 1'b1;
				ctrl.memRead = 1'b1;
				ctrl.aluSrc = 1'b1;
				ctrl.aluOp = aluAdd;
			end

			// Store word, no register write
			opSw:
			begin
				ctrl.memWrite = 1'b1;
				ctrl.aluSrc = 1'b1;
				ctrl.aluOp = aluAdd;
			end

			// Branch on equal
			// Execute subtracts, target resolved further down
			opBeq:
			begin
				ctrl.branch = 1'b1;
				ctrl.aluOp = aluSub;
			end

			// Add immediate into rt
			opAddi:
			begin
				ctrl.regWrite = 1'b1;
				ctrl.aluSrc = 1'b1;
				ctrl.aluOp = aluAdd;
			end

			// Set on less than immediate
			opSlti:
			begin
				ctrl.regWrite = 1'b1;
				ctrl.aluSrc = 1'b1;
				ctrl.aluOp = aluSlt;
			end

			// Anything else passes through as a bubble
			default:
			begin
				ctrl = '0;
			end
		endcase
	end

endmodule

// ==== verilog/registerFile.sv ====
`timescale 1ns/1ps

// 32 x 32 register file, one write port, two async reads
module registerFile
(
	input logic clk,
	input logic rst,
	input logic regWrite,
	input logic [mipsDecodePkg::REG_ADDR_W-1:0] regWriteAddr,
	input logic [mipsDecodePkg::DATA_W-1:0] regWriteData,
	regReadIf.file rd
);
	import mipsDecodePkg::*;

	// Storage, entry 0 is never written
	logic [DATA_W-1:0] regs [NUM_REGS];

	// Qualified write, drops writes to r0
	logic writeEn;

	assign writeEn = regWrite && (regWriteAddr != '0);

	// One read port
	// r0 reads zero, a write in flight to the same index wins
	function automatic logic [DATA_W-1:0] readPort(input logic [REG_ADDR_W-1:0] addr);
		logic [DATA_W-1:0] word;
		if (addr == '0)
			word = '0;
		else if (writeEn && (regWriteAddr == addr))
			word = regWriteData;
		else
			word = regs[addr];
		return word;
	endfunction

	//////////////////////////////
	// Write
	//////////////////////////////

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			for (int i = 0; i < NUM_REGS; i++)
				regs[i] <= '0;
		end
		else if (writeEn)
			regs[regWriteAddr] <= regWriteData;
	end

	//////////////////////////////
	// Read
	//////////////////////////////

	// Same rule on both ports
	always_comb
	begin
		rd.dataA = readPort(rd.rs);
		rd.dataB = readPort(rd.rt);
	end

endmodule

// ==== verilog/regReadIf.sv ====
`timescale 1ns/1ps

// Two-port register read bundle
// Addresses go out, data comes back in the same cycle
interface regReadIf;
	import mipsDecodePkg::*;

	// Source register indices from the instruction
	logic [REG_ADDR_W-1:0] rs;
	logic [REG_ADDR_W-1:0] rt;

	// Read data for rs
	logic [DATA_W-1:0] dataA;
	// Read data for rt
	logic [DATA_W-1:0] dataB;

	// Decode side
	modport reader
	(
		output rs,
		output rt,
		input dataA,
		input dataB
	);

	// Register file side
	modport file
	(
		input rs,
		input rt,
		output dataA,
		output dataB
	);

endinterface

// ==== verilog/mipsDecodePkg.sv ====
package mipsDecodePkg;

	//////////////////////////////
	// Widths
	//////////////////////////////

	// Data path word
	localparam int DATA_W = 32;

	// Register index, five bits for 32 entries
	localparam int REG_ADDR_W = 5;

	// Register file depth
	localparam int NUM_REGS = 32;

	// Immediate field of I-type instructions
	localparam int IMM_W = 16;

	//////////////////////////////
	// Encodings
	//////////////////////////////

	// Primary opcode, instruction bits 31..26
	typedef enum logic [5:0]
	{
		opRType = 6'h00,
		opBeq = 6'h04,
		opAddi = 6'h08,
		opSlti = 6'h0A,
		opLw = 6'h23,
		opSw = 6'h2B
	} opcodeT;

	// Operation requested from execute
	typedef enum logic [1:0]
	{
		// Address calc and addi
		aluAdd = 2'b00,
		// Compare for beq
		aluSub = 2'b01,
		// Execute looks at the funct field
		aluFunct = 2'b10,
		// Set on less than
		aluSlt = 2'b11
	} aluOpT;

	// Control word, grouped as WB / MEM / EX
	typedef struct packed
	{
		// Write-back group
		logic regWrite;
		logic memToReg;
		// Memory group
		logic branch;
		logic memRead;
		logic memWrite;
		// Execute group
		logic regDst;
		aluOpT aluOp;
		logic aluSrc;
	} ctrlT;

endpackage
